// File: tests/lsu_vectors.txt
// op(0 access,1 depth,2 idle,3 stalled) we size ext reg_off addr wdata
// exp_be exp_wdata exp_result (load value, or memory word after a store)
2 0 0 0 0 00000000 00000000 0 00000000 00000000
0 0 0 0 0 00000040 00000000 f 00000000 43424140
0 0 2 0 0 00000041 00000000 2 00000000 00000041
0 0 2 1 0 00000083 00000000 8 00000000 ffffff83
0 0 2 2 0 00000042 00000000 4 00000000 ffffff42
0 0 1 1 0 00000084 00000000 3 00000000 ffff8584
0 0 1 0 0 00000046 00000000 c 00000000 00004746
0 0 1 1 0 00000045 00000000 6 00000000 00004645
0 0 1 3 0 00000063 00000000 8 00000000 00006463
0 0 0 0 0 00000049 00000000 e 00000000 4c4b4a49
0 0 0 0 0 00000052 00000000 c 00000000 55545352
0 0 0 0 0 0000005b 00000000 8 00000000 5e5d5c5b
0 0 1 1 0 0000008f 00000000 8 00000000 ffff908f
0 1 0 0 0 000000c0 11223344 f 11223344 11223344
0 1 2 0 0 000000c5 000000ab 2 0000ab00 c7c6abc4
0 1 1 0 0 000000ca 0000beef c beef0000 beefc9c8
0 1 2 0 3 000000cf 5a000000 8 5a000000 5acecdcc
0 1 1 0 2 000000d1 cafe0000 6 00cafe00 d3cafed0
0 1 2 0 1 000000d6 00007700 4 00770000 d777d5d4
0 1 0 0 0 000000e1 11223344 e 22334411 223344e0
3 0 0 0 0 00000070 00000000 f 00000000 73727170
1 0 0 0 0 00000040 00000000 f 00000000 43424140
2 0 0 0 0 00000000 00000000 0 00000000 00000000

// File: verilog.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_ex_if.sv
rtl/lsu_req_format.sv
rtl/lsu_rdata_align.sv
rtl/lsu_txn_ctrl.sv
rtl/lsu_top.sv
tests/tb_clk_gen.sv
tests/lsu_assertions.sv
tests/tb_lsu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_lsu.sv
// load/store unit testbench, memory model and vector reader
// checks, watchdog and closing report

`timescale 1ns/1ps

module tb_lsu;

  localparam int col_op    = 0;
  localparam int col_we    = 1;
  localparam int col_size  = 2;
  localparam int col_ext   = 3;
  localparam int col_roff  = 4;
  localparam int col_addr  = 5;
  localparam int col_wdata = 6;
  localparam int col_be    = 7;
  localparam int col_wdo   = 8;
  localparam int col_res   = 9;

  logic        clk;
  logic        rst_n;
  logic        data_req;
  logic        data_gnt = 1'b0;
  logic        data_rvalid = 1'b0;
  logic        data_we;
  logic [31:0] data_addr;
  logic [3:0]  data_be;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata = 32'd0;
  logic        req_ex = 1'b0;
  logic        we_ex = 1'b0;
  logic [1:0]  size_ex = 2'b00;
  logic [31:0] wdata_ex = 32'd0;
  logic [1:0]  roff_ex = 2'b00;
  logic [1:0]  ext_ex = 2'b00;
  logic        mis_ex = 1'b0;
  logic [31:0] opa = 32'd0;
  logic [31:0] opb = 32'd0;
  logic        useincr = 1'b0;
  logic [31:0] rdata_ex;
  logic        misaligned;
  logic        ready_ex;
  logic        ready_wb;
  logic        busy;

  logic [31:0] mem [0:63];           // 256 bytes that start out holding their own addresses
  logic [31:0] vec [0:63][0:9];
  logic [31:0] rq_data [$];          // in-order responses
  int          rq_due [$];
  int          cyc = 0;
  int          gnt_mode = 0;         // 0 random, 1 high, 2 low
  bit          hold_resp = 1'b0;
  int          seed = 22633;
  int          n_vec = 0;
  int          errors = 0;
  int          n_checks = 0;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top lsu_top_inst (
    .clk (clk), .rst_n (rst_n),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_we_o (data_we), .data_addr_o (data_addr), .data_be_o (data_be),
    .data_wdata_o (data_wdata), .data_rdata_i (data_rdata),
    .data_req_ex_i (req_ex), .data_we_ex_i (we_ex), .data_size_ex_i (size_ex),
    .data_wdata_ex_i (wdata_ex), .data_reg_offset_ex_i (roff_ex),
    .data_sign_ext_ex_i (ext_ex), .data_misaligned_ex_i (mis_ex),
    .operand_a_ex_i (opa), .operand_b_ex_i (opb), .addr_useincr_ex_i (useincr),
    .data_rdata_ex_o (rdata_ex), .data_misaligned_o (misaligned),
    .lsu_ready_ex_o (ready_ex), .lsu_ready_wb_o (ready_wb), .busy_o (busy)
  );

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      data_gnt    <= 1'b0;
      data_rvalid <= 1'b0;
    end
    else
    begin
      cyc = cyc + 1;
      if (data_req && data_gnt)      // accepted so write now and answer 1 or 2 cycles on
      begin
        for (int j = 0; j < 4; j++)
          if (data_we && data_be[j])
            mem[data_addr[7:2]][8*j +: 8] = data_wdata[8*j +: 8];
        rq_data.push_back(mem[data_addr[7:2]]);
        rq_due.push_back(cyc + ($random(seed) & 1));
      end
      if (!hold_resp && rq_due.size() > 0 && rq_due[0] <= cyc)
      begin
        data_rvalid <= 1'b1;
        data_rdata  <= rq_data.pop_front();
        void'(rq_due.pop_front());
      end
      else
        data_rvalid <= 1'b0;
      case (gnt_mode)
        1: data_gnt <= 1'b1;
        2: data_gnt <= 1'b0;
        default: data_gnt <= (($random(seed) & 3) != 0);  // grant 3 times in 4
      endcase
    end
  end

  ////////////////////////////////////////
  // checks and access helpers
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got === exp)
    else
    begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_accept();
    do
    begin
      @(negedge clk);
      if (!(data_req && data_gnt))
        check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd0);  // stalled by gnt
    end while (!(data_req && data_gnt));
    check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd1);
  endtask

  task automatic wait_response();
    do
      @(negedge clk);
    while (!data_rvalid);
  endtask

  task automatic check_idle();
    @(negedge clk);
    check_val("busy_o", 32'(busy), 32'd0);
    check_val("data_req_o", 32'(data_req), 32'd0);
    check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd1);
    check_val("lsu_ready_wb_o", 32'(ready_wb), 32'd1);
  endtask

  // one access that is split in two phases when the unit flags it
  task automatic run_access(input int k, input bit stall);
    logic [31:0] addr;
    logic [1:0]  off;
    logic        exp_mis;
    addr    = vec[k][col_addr];
    off     = addr[1:0];
    exp_mis = (vec[k][col_size][1:0] == 2'b00 && off != 2'b00) ||
              (vec[k][col_size][1:0] == 2'b01 && off == 2'b11);
    if (stall)
      gnt_mode = 2;
    @(posedge clk);
    req_ex   <= 1'b1;
    we_ex    <= vec[k][col_we][0];
    size_ex  <= vec[k][col_size][1:0];
    ext_ex   <= vec[k][col_ext][1:0];
    roff_ex  <= vec[k][col_roff][1:0];
    wdata_ex <= vec[k][col_wdata];
    opa      <= addr - 32'd8;        // goes through the adder
    opb      <= 32'd8;
    useincr  <= 1'b1;
    mis_ex   <= 1'b0;
    if (stall)
    begin
      repeat (3)
      begin
        @(negedge clk);
        check_val("data_req_o", 32'(data_req), 32'd1);
        check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd0);
        check_val("data_addr_o", data_addr, addr);
      end
      gnt_mode = 0;
    end
    wait_accept();
    check_val("data_addr_o", data_addr, addr);
    check_val("data_we_o", 32'(data_we), 32'(vec[k][col_we][0]));
    check_val("data_be_o", 32'(data_be), vec[k][col_be]);
    check_val("data_misaligned_o", 32'(misaligned), 32'(exp_mis));
    if (vec[k][col_we][0])
      check_val("data_wdata_o", data_wdata, vec[k][col_wdo]);
    @(posedge clk);
    req_ex <= 1'b0;
    if (exp_mis)
    begin
      mis_ex <= 1'b1;                // keeps the raw first word in WB
      opa    <= addr - 32'd4;
    end
    wait_response();
    if (exp_mis)
    begin
      @(posedge clk);
      req_ex <= 1'b1;
      wait_accept();
      check_val("data_addr_o", data_addr, {addr[31:2] + 30'd1, 2'b00});
      check_val("data_misaligned_o", 32'(misaligned), 32'd0);
      @(posedge clk);
      req_ex <= 1'b0;
      mis_ex <= 1'b0;
      wait_response();
    end
    if (vec[k][col_we][0])
      check_val("memory word", mem[addr[7:2]], vec[k][col_res]);
    else
    begin
      check_val("data_rdata_ex_o", rdata_ex, vec[k][col_res]);
      @(negedge clk);
      check_val("data_rdata_ex_o held", rdata_ex, vec[k][col_res]);
    end
  endtask

  // two in flight while the third waits for a response
  task automatic run_depth(input int k);
    gnt_mode  = 1;
    hold_resp = 1'b1;
    @(posedge clk);
    req_ex  <= 1'b1;
    we_ex   <= 1'b0;
    size_ex <= 2'b00;
    opa     <= vec[k][col_addr];
    opb     <= 32'd0;
    useincr <= 1'b0;
    repeat (2)
    begin
      @(negedge clk);
      check_val("data_req_o", 32'(data_req), 32'd1);
    end
    @(negedge clk);
    check_val("data_req_o", 32'(data_req), 32'd0);  // two outstanding
    check_val("busy_o", 32'(busy), 32'd1);
    check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd0);
    hold_resp = 1'b0;
    wait_response();
    @(negedge clk);
    check_val("data_req_o", 32'(data_req), 32'd1);  // room again
    @(posedge clk);
    req_ex <= 1'b0;
    do
      @(negedge clk);
    while (busy);
    gnt_mode = 0;
    check_val("lsu_ready_ex_o", 32'(ready_ex), 32'd1);
    check_val("lsu_ready_wb_o", 32'(ready_wb), 32'd1);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    int          fd;
    int          e0;
    logic [31:0] t [0:9];
    logic [8*160-1:0] line_buf;
    for (int i = 0; i < 64; i++)
      mem[i] = {8'(4*i+3), 8'(4*i+2), 8'(4*i+1), 8'(4*i)};
    fd = $fopen("tests/lsu_vectors.txt", "r");
    if (fd == 0)
      $display("cannot open tests/lsu_vectors.txt");
    while (fd != 0 && !$feof(fd) && n_vec < 64)
    begin
      void'($fgets(line_buf, fd));
      if ($sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h", t[0], t[1], t[2], t[3],
                  t[4], t[5], t[6], t[7], t[8], t[9]) == 10)
      begin
        for (int c = 0; c < 10; c++)
          vec[n_vec][c] = t[c];
        n_vec++;
      end
    end
    if (fd != 0)
      $fclose(fd);
    if (n_vec == 0)
      errors++;
    fork
      begin
        repeat (n_vec * 50) @(posedge clk);
        $display("watchdog expired before all vectors finished");
        $display("Test failed");
        $finish;
      end
    join_none
    wait (rst_n);
    for (int k = 0; k < n_vec; k++)
    begin
      e0 = errors;
      case (vec[k][col_op])
        32'd1: run_depth(k);
        32'd2: check_idle();
        32'd3: run_access(k, 1'b1);
        default: run_access(k, 1'b0);
      endcase
      $display("vector %0d op %0d: %s", k, vec[k][col_op], (errors == e0) ? "pass" : "FAIL");
    end
    $display("%0d vectors, %0d checks, %0d errors", n_vec, n_checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: tests/lsu_assertions.sv
// bus protocol and outstanding counter properties
// bound into every lsu_txn_ctrl instance

`timescale 1ns/1ps

module lsu_assertions (
  input logic        clk,
  input logic        rst_n,
  input logic [1:0]  cnt,
  input logic        req,
  input logic        gnt,
  input logic        rvalid,
  input logic [31:0] addr
);

  // never more than two in flight
  cnt_limit_a: assert property (@(posedge clk) disable iff (!rst_n) cnt <= 2'd2)
    else $error("outstanding count above two");

  // an ungranted request stays up with the same address
  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !gnt) |=> (req && $stable(addr)))
    else $error("request dropped or changed before grant");

  // a response needs something outstanding
  rvalid_cnt_a: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> (cnt != 2'd0))
    else $error("rvalid with nothing outstanding");

endmodule

bind lsu_txn_ctrl lsu_assertions lsu_assertions_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .cnt    (cnt_q),
  .req    (data_req_o),
  .gnt    (data_gnt_i),
  .rvalid (data_rvalid_i),
  .addr   (data_addr_o)
);

// File: tests/tb_clk_gen.sv
// testbench clock with a 10 ns period
// active-low reset held for the first 3 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;                  // in reset from time zero
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #5 clk_o = ~clk_o;          // 100 MHz

endmodule

// File: rtl/lsu_top.sv
// load/store unit top level
// EX interface, request formatter, read aligner and transaction controller

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // data bus
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  output logic                 data_we_o,
  output logic [`LSU_XLEN-1:0] data_addr_o,
  output logic [`LSU_BE_W-1:0] data_be_o,
  output logic [`LSU_XLEN-1:0] data_wdata_o,
  input  logic [`LSU_XLEN-1:0] data_rdata_i,
  // EX stage
  input  logic                 data_req_ex_i,
  input  logic                 data_we_ex_i,
  input  logic [1:0]           data_size_ex_i,
  input  logic [`LSU_XLEN-1:0] data_wdata_ex_i,
  input  logic [1:0]           data_reg_offset_ex_i,
  input  logic [1:0]           data_sign_ext_ex_i,
  input  logic                 data_misaligned_ex_i,  // phase two of a split access
  input  logic [`LSU_XLEN-1:0] operand_a_ex_i,
  input  logic [`LSU_XLEN-1:0] operand_b_ex_i,
  input  logic                 addr_useincr_ex_i,
  output logic [`LSU_XLEN-1:0] data_rdata_ex_o,
  output logic                 data_misaligned_o,     // to the controller
  output logic                 lsu_ready_ex_o,
  output logic                 lsu_ready_wb_o,
  output logic                 busy_o
);

  logic [`LSU_XLEN-1:0] addr;
  logic [1:0]           addr_lsb;
  logic [`LSU_BE_W-1:0] be;
  logic [`LSU_XLEN-1:0] wdata;
  logic                 resp_valid;
  logic                 ctrl_update;

  lsu_ex_if ex_if_inst ();

  assign ex_if_inst.req           = data_req_ex_i;
  assign ex_if_inst.we            = data_we_ex_i;
  assign ex_if_inst.size          = data_size_ex_i;
  assign ex_if_inst.wdata         = data_wdata_ex_i;
  assign ex_if_inst.reg_offset    = data_reg_offset_ex_i;
  assign ex_if_inst.sign_ext      = data_sign_ext_ex_i;
  assign ex_if_inst.misaligned_ex = data_misaligned_ex_i;

  lsu_req_format lsu_req_format_inst (
    .ex_i           (ex_if_inst.fmt),
    .operand_a_i    (operand_a_ex_i),
    .operand_b_i    (operand_b_ex_i),
    .addr_useincr_i (addr_useincr_ex_i),
    .addr_o         (addr),
    .addr_lsb_o     (addr_lsb),
    .be_o           (be),
    .wdata_o        (wdata),
    .misaligned_o   (data_misaligned_o)
  );

  lsu_rdata_align lsu_rdata_align_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_i          (ex_if_inst.align),
    .addr_lsb_i    (addr_lsb),
    .ctrl_update_i (ctrl_update),
    .resp_valid_i  (resp_valid),
    .misaligned_i  (data_misaligned_o),
    .rdata_i       (data_rdata_i),        // seen as bytes and halves inside
    .rdata_ex_o    (data_rdata_ex_o)
  );

  lsu_txn_ctrl lsu_txn_ctrl_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_i           (ex_if_inst.ctrl),
    .addr_i         (addr),
    .be_i           (be),
    .wdata_i        (wdata),
    .we_i           (data_we_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_be_o      (data_be_o),
    .data_wdata_o   (data_wdata_o),
    .resp_valid_o   (resp_valid),
    .ctrl_update_o  (ctrl_update),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

endmodule

// File: rtl/lsu_txn_ctrl.sv
// transaction controller, outstanding counter and bus request
// EX/WB ready, busy and WB update strobe

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_txn_ctrl (
  input  logic                 clk,
  input  logic                 rst_n,
  lsu_ex_if.ctrl               ex_i,
  input  logic [`LSU_XLEN-1:0] addr_i,
  input  logic [`LSU_BE_W-1:0] be_i,
  input  logic [`LSU_XLEN-1:0] wdata_i,
  input  logic                 we_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output logic [`LSU_XLEN-1:0] data_addr_o,
  output logic [`LSU_BE_W-1:0] data_be_o,
  output logic [`LSU_XLEN-1:0] data_wdata_o,
  output logic                 resp_valid_o,   // rvalid with something outstanding
  output logic                 ctrl_update_o,  // load WB control registers
  output logic                 lsu_ready_ex_o,
  output logic                 lsu_ready_wb_o,
  output logic                 busy_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;     // outstanding transactions
  logic                  accept;    // req and gnt together

  // address phase straight from the formatter
  assign data_req_o   = ex_i.req && (cnt_q < `LSU_DEPTH);
  assign data_we_o    = we_i;
  assign data_addr_o  = addr_i;
  assign data_be_o    = be_i;
  assign data_wdata_o = wdata_i;

  assign accept       = data_req_o && data_gnt_i;
  assign resp_valid_o = data_rvalid_i && (cnt_q != '0);

  ////////////////////////////////////////
  // ready and busy
  ////////////////////////////////////////

  assign lsu_ready_wb_o = (cnt_q == '0) || resp_valid_o;

  // with WB occupied, EX only moves in step with a response
  always_comb
  begin
    if (!ex_i.req)
      lsu_ready_ex_o = 1'b1;
    else if (cnt_q == 2'd0)
      lsu_ready_ex_o = accept;
    else if (cnt_q == 2'd1)
      lsu_ready_ex_o = accept && resp_valid_o;
    else
      lsu_ready_ex_o = resp_valid_o;
  end

  assign ctrl_update_o = lsu_ready_ex_o && ex_i.req;
  assign busy_o        = (cnt_q != '0) || data_req_o;

  ////////////////////////////////////////
  // counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
    begin
      case ({accept, resp_valid_o})
        2'b10: cnt_q <= cnt_q + 2'd1;   // new one in flight
        2'b01: cnt_q <= cnt_q - 2'd1;   // one retired
        default: cnt_q <= cnt_q;        // none or one in and one out
      endcase
    end
  end

endmodule

// File: rtl/lsu_rdata_align.sv
// read-data aligner, WB control registers and held load value
// misaligned assembly and zero, one or sign extension

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_rdata_align (
  input  logic                 clk,
  input  logic                 rst_n,
  lsu_ex_if.align              ex_i,
  input  logic [1:0]           addr_lsb_i,      // offset of the access in EX
  input  logic                 ctrl_update_i,   // EX access moves to WB
  input  logic                 resp_valid_i,    // qualified rvalid
  input  logic                 misaligned_i,    // first phase of a split access in EX
  input  lsu_pkg::lsu_word_u   rdata_i,
  output logic [`LSU_XLEN-1:0] rdata_ex_o
);

  logic [1:0]           size_q;      // WB access size
  logic [1:0]           offset_q;    // WB byte offset
  logic [1:0]           sign_ext_q;  // WB extension mode
  logic                 we_q;        // WB access is a store
  lsu_pkg::lsu_word_u   rdata_q;     // raw first phase or last load result

  logic [`LSU_XLEN-1:0] word_res;
  logic [15:0]          half_raw;
  logic [7:0]           byte_raw;
  logic [`LSU_XLEN-1:0] rdata_ext;   // final load value

  // fill bit for the upper part of a short load
  function automatic logic fill_bit(input logic [1:0] mode, input logic msb);
    logic f;
    case (mode)
      `LSU_EXT_ZERO: f = 1'b0;
      `LSU_EXT_ONE:  f = 1'b1;
      default:       f = msb;      // sign with 11 included
    endcase
    return f;
  endfunction

  ////////////////////////////////////////
  // WB control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      size_q     <= `LSU_SIZE_WORD;
      offset_q   <= 2'b00;
      sign_ext_q <= `LSU_EXT_ZERO;
      we_q       <= 1'b0;
    end
    else if (ctrl_update_i)      // captured when EX is released
    begin
      size_q     <= ex_i.size;
      offset_q   <= addr_lsb_i;
      sign_ext_q <= ex_i.sign_ext;
      we_q       <= ex_i.we;
    end
  end

  ////////////////////////////////////////
  // alignment
  ////////////////////////////////////////

  // for words the upper lanes of the held word sit below the new low lanes
  always_comb
  begin
    case (offset_q)
      2'b01: word_res = {rdata_i.bytes[0], rdata_q.bytes[3:1]};
      2'b10: word_res = {rdata_i.halves[0], rdata_q.halves[1]};
      2'b11: word_res = {rdata_i.bytes[2:0], rdata_q.bytes[3]};
      default: word_res = rdata_i;
    endcase
  end

  always_comb
  begin
    case (offset_q)
      2'b00: half_raw = rdata_i.halves[0];
      2'b01: half_raw = {rdata_i.bytes[2], rdata_i.bytes[1]};  // straddles lanes 1 and 2
      2'b10: half_raw = rdata_i.halves[1];
      default: half_raw = {rdata_i.bytes[0], rdata_q.bytes[3]};  // split over two words
    endcase
  end

  assign byte_raw = rdata_i.bytes[offset_q];

  always_comb
  begin
    case (size_q)
      `LSU_SIZE_WORD: rdata_ext = word_res;
      `LSU_SIZE_HALF: rdata_ext = {{16{fill_bit(sign_ext_q, half_raw[15])}}, half_raw};
      default:        rdata_ext = {{24{fill_bit(sign_ext_q, byte_raw[7])}}, byte_raw};
    endcase
  end

  // raw word kept while phase two is pending and final value otherwise
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (resp_valid_i && !we_q)
    begin
      if (ex_i.misaligned_ex || misaligned_i)
        rdata_q <= rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  assign rdata_ex_o = resp_valid_i ? rdata_ext : rdata_q;  // bypass in the rvalid cycle

endmodule

// File: rtl/lsu_req_format.sv
// request formatter, address adder and byte enables
// store data rotation and misalignment detection

`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_req_format (
  lsu_ex_if.fmt                ex_i,
  input  logic [`LSU_XLEN-1:0] operand_a_i,
  input  logic [`LSU_XLEN-1:0] operand_b_i,
  input  logic                 addr_useincr_i,  // a + b when high and a alone when low
  output logic [`LSU_XLEN-1:0] addr_o,          // bus address
  output logic [1:0]           addr_lsb_o,      // byte offset for the aligner
  output logic [`LSU_BE_W-1:0] be_o,
  output logic [`LSU_XLEN-1:0] wdata_o,
  output logic                 misaligned_o     // split access, second phase needed
);

  logic [`LSU_XLEN-1:0] addr_int;    // raw effective address
  logic [1:0]           wdata_off;   // byte rotation amount

  ////////////////////////////////////////
  // address
  ////////////////////////////////////////

  assign addr_int   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_lsb_o = addr_int[1:0];

  // second phase goes to the next word and is always aligned
  assign addr_o = ex_i.misaligned_ex ? {addr_int[`LSU_XLEN-1:2], 2'b00} : addr_int;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb
  begin
    case (ex_i.size)
      `LSU_SIZE_WORD:
      begin
        if (!ex_i.misaligned_ex)
          be_o = 4'b1111 << addr_int[1:0];             // low part from the offset up
        else
          be_o = ~(4'b1111 << addr_int[1:0]);          // spill into the next word
      end
      `LSU_SIZE_HALF:
      begin
        if (!ex_i.misaligned_ex)
          be_o = 4'b0011 << addr_int[1:0];             // offset 3 keeps lane 3 only
        else
          be_o = 4'b0001;                              // upper byte of a split half
      end
      default: be_o = 4'b0001 << addr_int[1:0];        // byte in one lane
    endcase
  end

  ////////////////////////////////////////
  // store data
  ////////////////////////////////////////

  // register byte at reg_offset must land on lane addr offset
  assign wdata_off = addr_int[1:0] - ex_i.reg_offset;

  always_comb
  begin
    case (wdata_off)
      2'b00: wdata_o = ex_i.wdata;
      2'b01: wdata_o = {ex_i.wdata[23:0], ex_i.wdata[31:24]};  // up one lane
      2'b10: wdata_o = {ex_i.wdata[15:0], ex_i.wdata[31:16]};  // up two lanes
      2'b11: wdata_o = {ex_i.wdata[7:0],  ex_i.wdata[31:8]};   // up three lanes
      default: wdata_o = ex_i.wdata;
    endcase
  end

  // only first phases can be split; the controller then issues phase two
  always_comb
  begin
    misaligned_o = 1'b0;
    if (ex_i.req && !ex_i.misaligned_ex)
    begin
      if (ex_i.size == `LSU_SIZE_WORD)
        misaligned_o = (addr_int[1:0] != 2'b00);
      else if (ex_i.size == `LSU_SIZE_HALF)
        misaligned_o = (addr_int[1:0] == 2'b11);
    end
  end

endmodule

// File: rtl/lsu_ex_if.sv
// EX-stage access description of one load or store
// with one modport per consumer

`timescale 1ns/1ps
`include "lsu_config.svh"

interface lsu_ex_if;

  logic                 req;            // access requested in EX
  logic                 we;             // store when high
  logic [1:0]           size;           // word, half or byte
  logic [`LSU_XLEN-1:0] wdata;          // store data as held in the register
  logic [1:0]           reg_offset;     // byte offset inside the register
  logic [1:0]           sign_ext;       // zero, sign or one fill
  logic                 misaligned_ex;  // second phase of a split access

  // address, byte enables and store data
  modport fmt (
    input req,
    input we,
    input size,
    input wdata,
    input reg_offset,
    input misaligned_ex
  );

  // WB control capture and load shaping
  modport align (
    input we,
    input size,
    input sign_ext,
    input misaligned_ex
  );

  // bus request pacing
  modport ctrl (
    input req
  );

endinterface

// File: rtl/lsu_pkg.sv
// types of the load/store unit
// bus data word seen as bytes or halfwords

`include "lsu_config.svh"

package lsu_pkg;

  // one bus word with two ways of picking it apart
  typedef union packed {
    logic [`LSU_BE_W-1:0][7:0]     bytes;   // byte lanes 0..3
    logic [`LSU_BE_W/2-1:0][15:0]  halves;  // halfword lanes 0..1
  } lsu_word_u;

endpackage

// File: rtl/lsu_config.svh
// widths, depth, access-size codes and extension codes
// shared by the load/store unit

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data path
`define LSU_XLEN        32       // data and address width
`define LSU_BE_W        4        // one enable per byte

// outstanding transactions
`define LSU_DEPTH       2'd2     // max in flight on the bus
`define LSU_CNT_W       2        // counter width for 0..2

// access size where bit 1 set means byte
`define LSU_SIZE_WORD   2'b00
`define LSU_SIZE_HALF   2'b01
`define LSU_SIZE_BYTE   2'b10

// load extension where 11 behaves as sign
`define LSU_EXT_ZERO    2'b00
`define LSU_EXT_SIGN    2'b01
`define LSU_EXT_ONE     2'b10

`endif
